// File: common/stark_macros.svh
// defines for the functional unit count, queue depth, physical register count and value width
`ifndef STARK_MACROS_SVH
`define STARK_MACROS_SVH

// functional units feeding writeback, one result queue each
`define STARK_NUM_FU 3

// entries per result queue, also the credits a producer holds after reset
`define STARK_QUEUE_DEPTH 8

// physical registers behind the writeback bus
`define STARK_NUM_PREG 32

// result value width, a whole number of bytes so each byte gets a lane enable
`define STARK_VALUE_W 64

`endif

// File: common/stark_pkg.sv
// package with register number, tag, checkpoint, lane enable, value and result entry types
`include "stark_macros.svh"

package stark_pkg;

  // physical register number, wide enough to address every physical register
  typedef logic [$clog2(`STARK_NUM_PREG)-1:0] pregno_t;

  typedef logic [4:0] aregno_t;  // architectural register, kept for retirement later on

  typedef logic [7:0] tag_t;  // instruction tag broadcast for wakeup

  typedef logic [1:0] checkpt_ndx_t;  // checkpoint the result belongs to, only carried along

  // one enable per value byte in the low bits, the top bit clears the pending bit
  // all zero means there is no result this cycle
  typedef logic [`STARK_VALUE_W/8:0] lane_we_t;

  typedef logic [`STARK_VALUE_W-1:0] value_t;  // result value

  // one queue entry as it sits in storage and passes through the writeback mux
  typedef struct packed {
    lane_we_t     we;   // byte lanes plus pending clear
    pregno_t      prt;  // destination physical register
    aregno_t      art;  // destination architectural register
    tag_t         tag;  // tag of the producing instruction
    value_t       res;  // result value
    checkpt_ndx_t cp;   // checkpoint index
  } result_t;

endpackage

// File: result_queue/stark_result_queue.sv
// stark_result_queue, a credit-returning first-word-fall-through result FIFO for one unit
`timescale 1ns/1ps
`include "stark_macros.svh"

module stark_result_queue #(
  parameter int DEPTH = `STARK_QUEUE_DEPTH  // entries, equal to the producer's starting credits
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,       // synchronous, active low
  input  stark_pkg::lane_we_t     we_i,          // any nonzero lane enable is a push
  input  stark_pkg::pregno_t      prt_i,
  input  stark_pkg::aregno_t      art_i,
  input  stark_pkg::tag_t         tag_i,
  input  stark_pkg::value_t       res_i,
  input  stark_pkg::checkpt_ndx_t cp_i,
  output logic                    credit_o,      // one cycle pulse per entry that left
  output logic                    head_valid_o,  // head fields below hold a real entry
  output stark_pkg::lane_we_t     head_we_o,
  output stark_pkg::pregno_t      head_prt_o,
  output stark_pkg::aregno_t      head_art_o,
  output stark_pkg::tag_t         head_tag_o,
  output stark_pkg::value_t       head_res_o,
  output stark_pkg::checkpt_ndx_t head_cp_o,
  input  logic                    pop_i          // arbiter took the head this cycle
);
  import stark_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);  // count must reach DEPTH itself

  result_t          mem_q [DEPTH];  // circular entry storage
  logic [PTR_W-1:0] wr_ptr_q;       // next slot to fill
  logic [PTR_W-1:0] rd_ptr_q;       // slot shown at the head
  logic [CNT_W-1:0] count_q;        // entries held
  logic             push;
  logic             pop;
  result_t          head;

  // advance a pointer with wraparound, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = |we_i;                 // credits keep the producer off a full queue
  assign pop  = pop_i & head_valid_o;  // a pop of an empty queue is ignored

  // entry storage, written in the push cycle so the head shows it right after the edge
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= {we_i, prt_i, art_i, tag_i, res_i, cp_i};  // same order as result_t
    end
  end

  // pointers, occupancy and the credit return flop
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither leave the count alone
      endcase
      credit_o <= pop;  // freed slot goes back to the producer in the next cycle
    end
  end

  // fall-through head read straight out of storage
  assign head         = mem_q[rd_ptr_q];
  assign head_valid_o = (count_q != '0);
  assign head_we_o    = head.we;
  assign head_prt_o   = head.prt;
  assign head_art_o   = head.art;
  assign head_tag_o   = head.tag;
  assign head_res_o   = head.res;
  assign head_cp_o    = head.cp;

endmodule

// File: rtl/stark_wb_arbiter.sv
// stark_wb_arbiter, round-robin pick among queue heads that drives the writeback bus
`timescale 1ns/1ps
`include "stark_macros.svh"

module stark_wb_arbiter #(
  parameter int NUM_FU = `STARK_NUM_FU  // queues competing for the bus
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,       // synchronous, active low
  input  logic                    [NUM_FU-1:0] head_valid_i,  // one bit per queue head
  input  stark_pkg::lane_we_t     [NUM_FU-1:0] head_we_i,
  input  stark_pkg::pregno_t      [NUM_FU-1:0] head_prt_i,
  input  stark_pkg::tag_t         [NUM_FU-1:0] head_tag_i,
  input  stark_pkg::value_t       [NUM_FU-1:0] head_res_i,
  input  stark_pkg::checkpt_ndx_t [NUM_FU-1:0] head_cp_i,
  output logic                    [NUM_FU-1:0] pop_o,         // winner's head leaves at the edge
  output logic                                 wb_valid_o,    // bus holds a result this cycle
  output stark_pkg::lane_we_t                  wb_we_o,
  output stark_pkg::pregno_t                   wb_prt_o,
  output stark_pkg::tag_t                      wb_tag_o,
  output stark_pkg::value_t                    wb_res_o,
  output stark_pkg::checkpt_ndx_t              wb_cp_o
);
  import stark_pkg::*;

  localparam int IDX_W = (NUM_FU > 1) ? $clog2(NUM_FU) : 1;

  logic [IDX_W-1:0] prio_q;   // unit searched first, the one after the last winner
  logic [IDX_W-1:0] gnt_idx;  // winning unit
  logic             found;    // some head is valid
  result_t          win;      // winning head as one entry

  // rotating search starting at prio_q, first valid head wins
  always_comb begin : search
    int idx;
    found   = 1'b0;
    gnt_idx = prio_q;
    for (int k = 0; k < NUM_FU; k++) begin
      idx = int'(prio_q) + k;
      if (idx >= NUM_FU) begin
        idx = idx - NUM_FU;  // wrap back to unit 0
      end
      if (!found && head_valid_i[idx]) begin
        found   = 1'b1;
        gnt_idx = IDX_W'(idx);
      end
    end
  end

  // single pop toward the winning queue only
  always_comb begin : pop_decode
    pop_o = '0;
    if (found) begin
      pop_o[gnt_idx] = 1'b1;
    end
  end

  // head mux, the architectural register stays in the queue and rides as zero here
  always_comb begin : bus_mux
    win     = '0;
    win.we  = head_we_i[gnt_idx];
    win.prt = head_prt_i[gnt_idx];
    win.tag = head_tag_i[gnt_idx];
    win.res = head_res_i[gnt_idx];
    win.cp  = head_cp_i[gnt_idx];
  end

  assign wb_valid_o = found;
  assign wb_we_o    = win.we;   // muxed fields pass through when the bus is idle, valid says so
  assign wb_prt_o   = win.prt;
  assign wb_tag_o   = win.tag;
  assign wb_res_o   = win.res;
  assign wb_cp_o    = win.cp;

  // priority moves past the winner, an idle cycle keeps it where it is
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q <= '0;
    end else if (found) begin
      prio_q <= (gnt_idx == IDX_W'(NUM_FU - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

endmodule

// File: rtl/stark_prf.sv
// stark_prf, physical register file with byte lane writes, pending bits and one read port
`timescale 1ns/1ps
`include "stark_macros.svh"

module stark_prf #(
  parameter int NUM_FU   = `STARK_NUM_FU,    // units that can mark a register pending
  parameter int NUM_PREG = `STARK_NUM_PREG   // physical registers
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,        // synchronous, active low
  input  logic                            wb_valid_i,     // writeback bus carries a result
  input  stark_pkg::lane_we_t             wb_we_i,        // byte lanes plus pending clear
  input  stark_pkg::pregno_t              wb_prt_i,
  input  stark_pkg::value_t               wb_res_i,
  input  logic               [NUM_FU-1:0] set_pending_i,  // a unit pushed a pending-clearing result
  input  stark_pkg::pregno_t [NUM_FU-1:0] set_prt_i,      // register each unit is marking
  input  stark_pkg::pregno_t              rd_prt_i,
  output stark_pkg::value_t               rd_data_o,
  output logic                            rd_pending_o
);
  import stark_pkg::*;

  localparam int NUM_BYTES = $bits(value_t) / 8;  // the lane past the last byte is the pending clear

  value_t              regs_q [NUM_PREG];  // register values
  logic [NUM_PREG-1:0] pend_q;             // register still waits for its writeback
  logic [NUM_PREG-1:0] pend_d;

  // byte lane write at the writeback edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < NUM_PREG; r++) begin
        regs_q[r] <= '0;  // registers read as zero after reset
      end
    end else if (wb_valid_i) begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (wb_we_i[b]) begin
          regs_q[wb_prt_i][b*8 +: 8] <= wb_res_i[b*8 +: 8];
        end
      end
    end
  end

  // pending update, writeback clears first so that a same-edge set overrides it
  always_comb begin
    pend_d = pend_q;
    if (wb_valid_i && wb_we_i[NUM_BYTES]) begin
      pend_d[wb_prt_i] = 1'b0;
    end
    for (int u = 0; u < NUM_FU; u++) begin
      if (set_pending_i[u]) begin
        pend_d[set_prt_i[u]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_d;
    end
  end

  // combinational read, a write shows up here the cycle after its edge
  assign rd_data_o    = regs_q[rd_prt_i];
  assign rd_pending_o = pend_q[rd_prt_i];

endmodule

// File: rtl/stark_result_writeback.sv
// stark_result_writeback, top level with the result queues, writeback arbiter and register file
`timescale 1ns/1ps
`include "stark_macros.svh"

module stark_result_writeback (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,  // synchronous, active low
  input  stark_pkg::lane_we_t     [`STARK_NUM_FU-1:0]   fu_we_i,  // per unit, nonzero pushes
  input  stark_pkg::pregno_t      [`STARK_NUM_FU-1:0]   fu_prt_i,
  input  stark_pkg::aregno_t      [`STARK_NUM_FU-1:0]   fu_art_i,
  input  stark_pkg::tag_t         [`STARK_NUM_FU-1:0]   fu_tag_i,
  input  stark_pkg::value_t       [`STARK_NUM_FU-1:0]   fu_res_i,
  input  stark_pkg::checkpt_ndx_t [`STARK_NUM_FU-1:0]   fu_cp_i,
  output logic                    [`STARK_NUM_FU-1:0]   fu_credit_o,  // credit pulse per unit
  output logic                                          wb_valid_o,   // writeback this cycle
  output stark_pkg::tag_t                               wb_tag_o,     // wakeup tag
  output stark_pkg::pregno_t                            wb_prt_o,
  output stark_pkg::checkpt_ndx_t                       wb_cp_o,
  input  stark_pkg::pregno_t                            rd_prt_i,
  output stark_pkg::value_t                             rd_data_o,
  output logic                                          rd_pending_o
);
  import stark_pkg::*;

  localparam int NUM_FU = `STARK_NUM_FU;

  logic         [NUM_FU-1:0] head_valid;  // queue heads toward the arbiter
  lane_we_t     [NUM_FU-1:0] head_we;
  pregno_t      [NUM_FU-1:0] head_prt;
  tag_t         [NUM_FU-1:0] head_tag;
  value_t       [NUM_FU-1:0] head_res;
  checkpt_ndx_t [NUM_FU-1:0] head_cp;
  logic         [NUM_FU-1:0] pop;         // arbiter grant back to each queue
  logic         [NUM_FU-1:0] set_pend;    // push that will clear pending later marks it now
  lane_we_t                  wb_we;       // bus fields that only the register file needs
  value_t                    wb_res;

  for (genvar u = 0; u < NUM_FU; u++) begin : g_fu
    assign set_pend[u] = fu_we_i[u][$bits(lane_we_t)-1];  // top lane is the pending clear

    stark_result_queue #(
      .DEPTH(`STARK_QUEUE_DEPTH)
    ) i_queue (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .we_i        (fu_we_i[u]),
      .prt_i       (fu_prt_i[u]),
      .art_i       (fu_art_i[u]),
      .tag_i       (fu_tag_i[u]),
      .res_i       (fu_res_i[u]),
      .cp_i        (fu_cp_i[u]),
      .credit_o    (fu_credit_o[u]),
      .head_valid_o(head_valid[u]),
      .head_we_o   (head_we[u]),
      .head_prt_o  (head_prt[u]),
      .head_art_o  (),  // kept in the entry for retirement, not needed at writeback
      .head_tag_o  (head_tag[u]),
      .head_res_o  (head_res[u]),
      .head_cp_o   (head_cp[u]),
      .pop_i       (pop[u])
    );
  end

  stark_wb_arbiter #(
    .NUM_FU(NUM_FU)
  ) i_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .head_valid_i(head_valid),
    .head_we_i   (head_we),
    .head_prt_i  (head_prt),
    .head_tag_i  (head_tag),
    .head_res_i  (head_res),
    .head_cp_i   (head_cp),
    .pop_o       (pop),
    .wb_valid_o  (wb_valid_o),
    .wb_we_o     (wb_we),
    .wb_prt_o    (wb_prt_o),
    .wb_tag_o    (wb_tag_o),
    .wb_res_o    (wb_res),
    .wb_cp_o     (wb_cp_o)
  );

  stark_prf #(
    .NUM_FU  (NUM_FU),
    .NUM_PREG(`STARK_NUM_PREG)
  ) i_prf (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .wb_valid_i   (wb_valid_o),
    .wb_we_i      (wb_we),
    .wb_prt_i     (wb_prt_o),
    .wb_res_i     (wb_res),
    .set_pending_i(set_pend),
    .set_prt_i    (fu_prt_i),
    .rd_prt_i     (rd_prt_i),
    .rd_data_o    (rd_data_o),
    .rd_pending_o (rd_pending_o)
  );

endmodule

// File: tests/stark_result_writeback_checker.sv
// stark_result_writeback_checker, bound assertions on queue room, bus validity and grant fairness
`timescale 1ns/1ps
`include "stark_macros.svh"

module stark_result_writeback_checker #(
  parameter int NUM_FU = `STARK_NUM_FU,       // queues behind the arbiter
  parameter int DEPTH  = `STARK_QUEUE_DEPTH   // entries per queue
) (
  input logic                             clk_i,
  input logic                             rst_n_i,       // synchronous, active low
  input stark_pkg::lane_we_t [NUM_FU-1:0] fu_we_i,       // producer pushes
  input logic                [NUM_FU-1:0] head_valid_i,  // queue heads toward the arbiter
  input logic                [NUM_FU-1:0] pop_i,         // arbiter grants
  input logic                             wb_valid_i     // writeback bus busy
);
  import stark_pkg::*;

  int          occ_q  [NUM_FU];  // occupancy rebuilt from pushes and accepted pops
  int          wait_q [NUM_FU];  // grants to other units while this head waits
  int unsigned fired_count = 0;  // failed assertions, looked at by the testbench at the end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int u = 0; u < NUM_FU; u++) begin
        occ_q[u]  <= 0;
        wait_q[u] <= 0;
      end
    end else begin
      for (int u = 0; u < NUM_FU; u++) begin
        occ_q[u] <= occ_q[u] + int'(|fu_we_i[u]) - int'(pop_i[u] & head_valid_i[u]);
        if (pop_i[u] || !head_valid_i[u]) begin
          wait_q[u] <= 0;  // served or nothing waiting
        end else if (wb_valid_i) begin
          wait_q[u] <= wait_q[u] + 1;  // someone else got the bus
        end
      end
    end
  end

  for (genvar u = 0; u < NUM_FU; u++) begin : g_unit
    // a producer holding a credit never finds its queue full
    a_push_with_room: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (|fu_we_i[u]) |-> (occ_q[u] < DEPTH))
      else begin
        fired_count++;
        $error("unit %0d pushed while its queue was full", u);
      end

    // round robin lets at most the other units go first
    a_bounded_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wait_q[u] < NUM_FU)
      else begin
        fired_count++;
        $error("unit %0d waited %0d grants with a valid head", u, wait_q[u]);
      end
  end

  a_valid_needs_head: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_i |-> (|head_valid_i))
    else begin
      fired_count++;
      $error("writeback bus valid with every queue head empty");
    end

endmodule

bind stark_result_writeback stark_result_writeback_checker i_checker (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .fu_we_i     (fu_we_i),
  .head_valid_i(head_valid),
  .pop_i       (pop),
  .wb_valid_i  (wb_valid_o)
);

// File: tests/stark_result_writeback_tb.sv
// testbench for stark_result_writeback with random credit-based producers and a reference model
`timescale 1ns/1ps
`include "stark_macros.svh"

module stark_result_writeback_tb;
  import stark_pkg::*;

  localparam int NUM_FU       = `STARK_NUM_FU;
  localparam int DEPTH        = `STARK_QUEUE_DEPTH;
  localparam int NUM_PREG     = `STARK_NUM_PREG;
  localparam int NUM_BYTES    = `STARK_VALUE_W / 8;
  localparam int RESET_CYCLES = 8;
  localparam int STIM_CYCLES  = 1500;                // random traffic in segments of mixed rate
  localparam int BURST_CYCLES = 230;                 // every producer pushes whenever it can
  localparam int DRAIN_CYCLES = 4 * NUM_FU * DEPTH;  // ample time to empty every queue
  localparam int WORK_CYCLES  = RESET_CYCLES + 2 * (NUM_PREG + 1) + STIM_CYCLES
                                + BURST_CYCLES + DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * WORK_CYCLES + 200;  // twice the work plus slack, 4000

  logic                      clk;
  logic                      rst_n;
  lane_we_t     [NUM_FU-1:0] fu_we;
  pregno_t      [NUM_FU-1:0] fu_prt;
  aregno_t      [NUM_FU-1:0] fu_art;
  tag_t         [NUM_FU-1:0] fu_tag;
  value_t       [NUM_FU-1:0] fu_res;
  checkpt_ndx_t [NUM_FU-1:0] fu_cp;
  logic         [NUM_FU-1:0] fu_credit;
  logic                      wb_valid;
  tag_t                      wb_tag;
  pregno_t                   wb_prt;
  checkpt_ndx_t              wb_cp;
  pregno_t                   rd_prt;
  value_t                    rd_data;
  logic                      rd_pending;

  result_t model_q [NUM_FU][$];     // results each queue should still hold, oldest first
  int      credits [NUM_FU];        // producer credit counts
  value_t  model_regs [NUM_PREG];   // expected register values
  logic    model_pend [NUM_PREG];   // expected pending bits
  int      rr_next   = 0;           // unit the arbiter searches first
  tag_t    next_tag  = '0;          // tags count up so outstanding ones never repeat
  int      cycle_cnt = 0;
  int      wb_count  = 0;           // writebacks seen on the bus

  stark_result_writeback i_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .fu_we_i     (fu_we),
    .fu_prt_i    (fu_prt),
    .fu_art_i    (fu_art),
    .fu_tag_i    (fu_tag),
    .fu_res_i    (fu_res),
    .fu_cp_i     (fu_cp),
    .fu_credit_o (fu_credit),
    .wb_valid_o  (wb_valid),
    .wb_tag_o    (wb_tag),
    .wb_prt_o    (wb_prt),
    .wb_cp_o     (wb_cp),
    .rd_prt_i    (rd_prt),
    .rd_data_o   (rd_data),
    .rd_pending_o(rd_pending)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;  // 8 ns period
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $fatal(1, "stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h at cycle %0d",
               name, actual, expected, cycle_cnt);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // first unit with a queued result, searching from the round-robin pointer
  function automatic int expected_winner();
    int u;
    for (int k = 0; k < NUM_FU; k++) begin
      u = (rr_next + k) % NUM_FU;
      if (model_q[u].size() > 0) begin
        return u;
      end
    end
    return -1;
  endfunction

  // byte lanes land in the register, the top lane releases the pending bit
  task automatic apply_writeback(input result_t ent);
    for (int b = 0; b < NUM_BYTES; b++) begin
      if (ent.we[b]) begin
        model_regs[ent.prt][b*8 +: 8] = ent.res[b*8 +: 8];
      end
    end
    if (ent.we[NUM_BYTES]) begin
      model_pend[ent.prt] = 1'b0;
    end
  endtask

  // one producer either pushes a fresh result or idles with junk on the fields
  task automatic drive_unit(input int u, input int push_pct);
    result_t ent;
    ent.we  = lane_we_t'($urandom_range((1 << (NUM_BYTES + 1)) - 1, 1));
    ent.prt = pregno_t'($urandom);
    ent.art = aregno_t'($urandom);
    ent.tag = next_tag;
    ent.res = {$urandom, $urandom};
    ent.cp  = checkpt_ndx_t'($urandom);
    if (credits[u] > 0 && int'($urandom_range(99, 0)) < push_pct) begin
      credits[u]--;
      next_tag++;
      model_q[u].push_back(ent);
      if (ent.we[NUM_BYTES]) begin
        model_pend[ent.prt] = 1'b1;  // applied after this cycle's clear, so the set wins
      end
    end else begin
      ent.we = '0;  // no push this cycle
    end
    fu_we[u]  = ent.we;
    fu_prt[u] = ent.prt;
    fu_art[u] = ent.art;
    fu_tag[u] = ent.tag;
    fu_res[u] = ent.res;
    fu_cp[u]  = ent.cp;
  endtask

  // one clock cycle, everything sampled and driven at the falling edge
  task automatic step(input int push_pct, input int rd_sel);
    int      exp_u;
    int      hits;
    result_t head;
    @(negedge clk);
    check_value("rd_data_o", rd_data, model_regs[rd_prt]);  // state after the last edge
    check_value("rd_pending_o", rd_pending, model_pend[rd_prt]);
    for (int u = 0; u < NUM_FU; u++) begin
      if (fu_credit[u]) begin
        credits[u]++;
      end
      check_value("credit count in range", credits[u] >= 0 && credits[u] <= DEPTH, 1);
    end
    exp_u = expected_winner();
    check_value("wb_valid_o", wb_valid, exp_u >= 0);  // a waiting result is never left idle
    if (exp_u >= 0) begin
      head = model_q[exp_u][0];
      hits = 0;
      for (int u = 0; u < NUM_FU; u++) begin
        if (model_q[u].size() > 0 && model_q[u][0].tag == wb_tag) begin
          hits++;
        end
      end
      check_value("heads matching wb_tag_o", hits, 1);
      check_value("wb_tag_o", wb_tag, head.tag);
      check_value("wb_prt_o", wb_prt, head.prt);
      check_value("wb_cp_o", wb_cp, head.cp);
      apply_writeback(head);
      void'(model_q[exp_u].pop_front());
      rr_next = (exp_u + 1) % NUM_FU;
      wb_count++;
    end
    for (int u = 0; u < NUM_FU; u++) begin
      drive_unit(u, push_pct);
    end
    rd_prt = (rd_sel < 0) ? pregno_t'($urandom) : pregno_t'(rd_sel);
  endtask

  // every queued result has been written back
  function automatic bit drained();
    for (int u = 0; u < NUM_FU; u++) begin
      if (model_q[u].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  initial begin
    void'($urandom(21642));
    rst_n  = 1'b0;
    fu_we  = '0;
    fu_prt = '0;
    fu_art = '0;
    fu_tag = '0;
    fu_res = '0;
    fu_cp  = '0;
    rd_prt = '0;
    for (int r = 0; r < NUM_PREG; r++) begin
      model_regs[r] = '0;
      model_pend[r] = 1'b0;
    end
    for (int u = 0; u < NUM_FU; u++) begin
      credits[u] = DEPTH;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // quiet sweep right after reset, every register zero and idle bus
    for (int r = 0; r <= NUM_PREG; r++) begin
      step(0, (r < NUM_PREG) ? r : 0);
      check_value("fu_credit_o after reset", fu_credit, '0);
    end

    // random traffic, push rate changes every 250 cycles
    for (int c = 0; c < STIM_CYCLES; c++) begin
      step(25 + 35 * ((c / 250) % 3), -1);
    end

    // burst, the bus must stay busy every cycle once the heads fill
    for (int c = 0; c < BURST_CYCLES; c++) begin
      step(100, -1);
      if (c > 0) begin
        check_value("wb_valid_o during burst", wb_valid, 1);
      end
    end

    while (!drained()) begin
      step(0, -1);
    end
    step(0, -1);  // the last pop returns its credit one cycle later
    for (int u = 0; u < NUM_FU; u++) begin
      check_value("credits after drain", credits[u], DEPTH);
    end

    // final sweep through every register
    for (int r = 0; r <= NUM_PREG; r++) begin
      step(0, (r < NUM_PREG) ? r : 0);
    end

    $display("writebacks checked: %0d", wb_count);
    if (i_dut.i_checker.fired_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("bound assertions failed %0d times", i_dut.i_checker.fired_count);
      $display("RESULT: FAIL");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// File: sim.f
+incdir+common
common/stark_pkg.sv
result_queue/stark_result_queue.sv
rtl/stark_wb_arbiter.sv
rtl/stark_prf.sv
rtl/stark_result_writeback.sv
tests/stark_result_writeback_checker.sv
tests/stark_result_writeback_tb.sv

// File: Makefile
# Verilator build and run for the result writeback stage

VERILATOR  ?= verilator
TOP        := stark_result_writeback_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the log decides the result, the simulator's own exit status is not relied on
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
